// File: iwd_defines.svh
// ******************************************************************
// Lane count, per-lane read depth and field widths of the AXI read
// ID downsizer, included wherever the sizes are needed
// ******************************************************************
`ifndef IWD_DEFINES_SVH
`define IWD_DEFINES_SVH

// Number of lanes and of master IDs in use
`define IWD_NUM_IDS      4
// Reads in flight per lane
`define IWD_MAX_TRANS    4

`define IWD_SLV_ID_WIDTH 6
`define IWD_MST_ID_WIDTH 2
`define IWD_ADDR_WIDTH   32
`define IWD_DATA_WIDTH   32
`define IWD_LEN_WIDTH    8

`endif

// File: iwd_pkg.sv
// ******************************************************************
// Shared vector types of the AXI read ID downsizer, used by the
// RTL modules and the testbench
// ******************************************************************
`include "iwd_defines.svh"

package iwd_pkg;

  // Channel fields
  typedef logic [`IWD_SLV_ID_WIDTH-1:0] slv_id_t;
  typedef logic [`IWD_MST_ID_WIDTH-1:0] mst_id_t;
  typedef logic [`IWD_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`IWD_DATA_WIDTH-1:0]   data_t;
  typedef logic [`IWD_LEN_WIDTH-1:0]    len_t;

  // Lane bookkeeping
  typedef logic [$clog2(`IWD_NUM_IDS)-1:0]     lane_t;
  typedef logic [`IWD_NUM_IDS-1:0]             lane_vec_t;
  // Must hold the value IWD_MAX_TRANS itself
  typedef logic [$clog2(`IWD_MAX_TRANS+1)-1:0] count_t;

endpackage

// File: iwd_router.sv
// ******************************************************************
// Combinational AR lane decode and R return routing; picks the lane
// from the slave ID and puts the lane's slave ID back on R beats
// ******************************************************************
`timescale 1ns/100ps
`include "iwd_defines.svh"

module iwd_router (
  input  logic                                       slv_ar_valid_i,
  input  iwd_pkg::slv_id_t                           slv_ar_id_i,
  input  iwd_pkg::lane_vec_t                         lane_ar_ready_i,
  input  logic                                       mst_r_valid_i,
  input  logic                                       mst_r_ready_i,
  input  logic                                       mst_r_last_i,
  input  iwd_pkg::mst_id_t                           mst_r_id_i,
  input  iwd_pkg::slv_id_t [`IWD_NUM_IDS-1:0]        lane_id_i,
  output iwd_pkg::lane_vec_t                         lane_ar_valid_o,
  output iwd_pkg::lane_t                             lane_sel_o,
  output logic                                       ar_fire_o,
  output logic                                       slv_ar_ready_o,
  output iwd_pkg::lane_vec_t                         lane_r_done_o,
  output iwd_pkg::slv_id_t                           slv_r_id_o
);
  import iwd_pkg::*;

  lane_t ar_lane;
  lane_t r_lane;
  logic  r_last_hs;

  // Lane of an AR is its slave ID modulo the lane count
  assign ar_lane = lane_t'(slv_ar_id_i % `IWD_NUM_IDS);

  always_comb begin
    lane_ar_valid_o          = '0;
    lane_ar_valid_o[ar_lane] = slv_ar_valid_i;
  end

  assign slv_ar_ready_o = lane_ar_ready_i[ar_lane];
  assign ar_fire_o      = slv_ar_valid_i & slv_ar_ready_o;
  assign lane_sel_o     = ar_lane;

  // Master ID is the lane index
  assign r_lane     = lane_t'(mst_r_id_i);
  assign slv_r_id_o = lane_id_i[r_lane];

  // Only the last beat of a burst frees a lane slot
  assign r_last_hs = mst_r_valid_i & mst_r_ready_i & mst_r_last_i;

  always_comb begin
    lane_r_done_o         = '0;
    lane_r_done_o[r_lane] = r_last_hs;
  end

endmodule

// File: iwd_id_lane.sv
// ******************************************************************
// One ID lane; keeps all reads in flight on a single slave ID and
// counts them so the ID can be restored on the returning R beats
// ******************************************************************
`timescale 1ns/100ps
`include "iwd_defines.svh"

module iwd_id_lane (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             ar_valid_i,
  input  iwd_pkg::slv_id_t ar_id_i,
  input  logic             issue_ready_i,
  input  logic             r_done_i,
  output logic             ar_ready_o,
  output iwd_pkg::slv_id_t cur_id_o
);
  import iwd_pkg::*;

  count_t  count_q;
  count_t  count_d;
  slv_id_t cur_id_q;
  logic    lane_empty;
  logic    same_id_room;
  logic    admit;

  assign lane_empty   = (count_q == '0);
  assign same_id_room = (ar_id_i == cur_id_q) &&
                        (count_q < count_t'(`IWD_MAX_TRANS));

  // A different ID has to wait until the lane has drained
  assign ar_ready_o = issue_ready_i & (lane_empty | same_id_room);
  assign admit      = ar_valid_i & ar_ready_o;

  always_comb begin
    count_d = count_q;
    if (admit && !r_done_i) begin
      count_d = count_q + count_t'(1);
    end else if (!admit && r_done_i) begin
      count_d = count_q - count_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // ID of the reads now in flight
  always_ff @(posedge clk_i) begin
    if (admit) begin
      cur_id_q <= ar_id_i;
    end
  end

  assign cur_id_o = cur_id_q;

  // Router must not report a finished burst the lane never admitted
  a_no_done_when_empty : assert property (
    @(posedge clk_i) disable iff (reset_i)
    r_done_i |-> !lane_empty
  );

  a_count_bound : assert property (
    @(posedge clk_i) disable iff (reset_i)
    count_q <= count_t'(`IWD_MAX_TRANS)
  );

endmodule

// File: iwd_ar_issue.sv
// ******************************************************************
// One-entry register slice on the master AR channel; the lane index
// of each request goes out as the narrow master ID
// ******************************************************************
`timescale 1ns/100ps

module iwd_ar_issue (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  iwd_pkg::lane_t   lane_i,
  input  iwd_pkg::addr_t   addr_i,
  input  iwd_pkg::len_t    len_i,
  input  logic             mst_ar_ready_i,
  output logic             ready_o,
  output logic             mst_ar_valid_o,
  output iwd_pkg::mst_id_t mst_ar_id_o,
  output iwd_pkg::addr_t   mst_ar_addr_o,
  output iwd_pkg::len_t    mst_ar_len_o
);
  import iwd_pkg::*;

  logic    valid_q;
  mst_id_t id_q;
  addr_t   addr_q;
  len_t    len_q;

  // Free now, or emptied by the master in this cycle
  assign ready_o = ~valid_q | mst_ar_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (push_i) begin
      valid_q <= 1'b1;
    end else if (valid_q && mst_ar_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q   <= mst_id_t'(lane_i);   // zero-extended lane index
      addr_q <= addr_i;
      len_q  <= len_i;
    end
  end

  assign mst_ar_valid_o = valid_q;
  assign mst_ar_id_o    = id_q;
  assign mst_ar_addr_o  = addr_q;
  assign mst_ar_len_o   = len_q;

  // Held request keeps its payload until the master takes it
  a_ar_stable : assert property (
    @(posedge clk_i) disable iff (reset_i)
    valid_q && !mst_ar_ready_i |=>
      valid_q && $stable(id_q) && $stable(addr_q) && $stable(len_q)
  );

  // Lanes only admit while this stage can take the request
  a_push_when_ready : assert property (
    @(posedge clk_i) disable iff (reset_i)
    push_i |-> ready_o
  );

endmodule

// File: iwd_downsizer.sv
// ******************************************************************
// Top of the AXI read ID downsizer; wide slave IDs are serialized
// per lane and leave the master port with the lane index as ID
// ******************************************************************
`timescale 1ns/100ps
`include "iwd_defines.svh"

module iwd_downsizer (
  input  logic             clk_i,
  input  logic             reset_i,
  // Slave AR
  input  logic             slv_ar_valid_i,
  output logic             slv_ar_ready_o,
  input  iwd_pkg::slv_id_t slv_ar_id_i,
  input  iwd_pkg::addr_t   slv_ar_addr_i,
  input  iwd_pkg::len_t    slv_ar_len_i,
  // Slave R
  output logic             slv_r_valid_o,
  input  logic             slv_r_ready_i,
  output iwd_pkg::slv_id_t slv_r_id_o,
  output iwd_pkg::data_t   slv_r_data_o,
  output logic             slv_r_last_o,
  // Master AR
  output logic             mst_ar_valid_o,
  input  logic             mst_ar_ready_i,
  output iwd_pkg::mst_id_t mst_ar_id_o,
  output iwd_pkg::addr_t   mst_ar_addr_o,
  output iwd_pkg::len_t    mst_ar_len_o,
  // Master R
  input  logic             mst_r_valid_i,
  output logic             mst_r_ready_o,
  input  iwd_pkg::mst_id_t mst_r_id_i,
  input  iwd_pkg::data_t   mst_r_data_i,
  input  logic             mst_r_last_i
);
  import iwd_pkg::*;

  lane_vec_t                    lane_ar_valid;
  lane_vec_t                    lane_ar_ready;
  lane_vec_t                    lane_r_done;
  slv_id_t [`IWD_NUM_IDS-1:0]   lane_cur_id;
  lane_t                        lane_sel;
  logic                         ar_fire;
  logic                         issue_ready;

  iwd_router u_router (
    .slv_ar_valid_i  (slv_ar_valid_i),
    .slv_ar_id_i     (slv_ar_id_i),
    .lane_ar_ready_i (lane_ar_ready),
    .mst_r_valid_i   (mst_r_valid_i),
    .mst_r_ready_i   (slv_r_ready_i),
    .mst_r_last_i    (mst_r_last_i),
    .mst_r_id_i      (mst_r_id_i),
    .lane_id_i       (lane_cur_id),
    .lane_ar_valid_o (lane_ar_valid),
    .lane_sel_o      (lane_sel),
    .ar_fire_o       (ar_fire),
    .slv_ar_ready_o  (slv_ar_ready_o),
    .lane_r_done_o   (lane_r_done),
    .slv_r_id_o      (slv_r_id_o)
  );

  for (genvar i = 0; i < `IWD_NUM_IDS; i++) begin : gen_lane
    iwd_id_lane u_lane (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .ar_valid_i    (lane_ar_valid[i]),
      .ar_id_i       (slv_ar_id_i),
      .issue_ready_i (issue_ready),
      .r_done_i      (lane_r_done[i]),
      .ar_ready_o    (lane_ar_ready[i]),
      .cur_id_o      (lane_cur_id[i])
    );
  end

  iwd_ar_issue u_ar_issue (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .push_i         (ar_fire),
    .lane_i         (lane_sel),
    .addr_i         (slv_ar_addr_i),
    .len_i          (slv_ar_len_i),
    .mst_ar_ready_i (mst_ar_ready_i),
    .ready_o        (issue_ready),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_id_o    (mst_ar_id_o),
    .mst_ar_addr_o  (mst_ar_addr_o),
    .mst_ar_len_o   (mst_ar_len_o)
  );

  // R payload and handshake pass straight through
  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign mst_r_ready_o = slv_r_ready_i;

endmodule

// File: tb_iwd_downsizer.sv
// ******************************************************************
// Self-checking testbench for the AXI read ID downsizer; random reads
// run against a memory model and assertions check both ports
// ******************************************************************
`timescale 1ns/100ps
`include "iwd_defines.svh"

module tb_iwd_downsizer;
  import iwd_pkg::*;

  localparam int NUM_READS  = 200;
  localparam int CLK_PERIOD = 20;

  logic    clk_i          = 1'b0;
  logic    reset_i        = 1'b1;
  logic    slv_ar_valid_i = 1'b0;
  slv_id_t slv_ar_id_i    = '0;
  addr_t   slv_ar_addr_i  = '0;
  len_t    slv_ar_len_i   = '0;
  logic    slv_r_ready_i  = 1'b0;
  logic    mst_ar_ready_i = 1'b0;
  logic    mst_r_valid_i  = 1'b0;
  mst_id_t mst_r_id_i     = '0;
  data_t   mst_r_data_i   = '0;
  logic    mst_r_last_i   = 1'b0;
  logic    slv_ar_ready_o;
  logic    slv_r_valid_o;
  slv_id_t slv_r_id_o;
  data_t   slv_r_data_o;
  logic    slv_r_last_o;
  logic    mst_ar_valid_o;
  mst_id_t mst_ar_id_o;
  addr_t   mst_ar_addr_o;
  len_t    mst_ar_len_o;
  logic    mst_r_ready_o;

  // Handshakes seen at the falling edge, completed at the next rising edge
  logic    slv_ar_hs = 1'b0;
  logic    mst_ar_hs = 1'b0;
  logic    r_hs      = 1'b0;
  // Master AR held under back-pressure
  logic    held_ar   = 1'b0;
  mst_id_t held_id;
  addr_t   held_addr;
  len_t    held_len;
  lane_t   ar_lane;
  logic    exp_ready;
  slv_id_t head_id;
  int      reads_sent = 0;
  int      reads_done = 0;

  // Scoreboard of expected slave IDs per lane, and master ARs in order
  slv_id_t exp_id_q[`IWD_NUM_IDS][$];
  mst_id_t exp_ar_id_q[$];
  addr_t   exp_ar_addr_q[$];
  len_t    exp_ar_len_q[$];

  // Memory model state
  addr_t   mem_addr_q[`IWD_NUM_IDS][$];
  len_t    mem_len_q[`IWD_NUM_IDS][$];
  logic    busy = 1'b0;
  int      beat = 0;
  int      start;
  int      cand;
  mst_id_t r_id   = '0;
  addr_t   r_addr = '0;
  len_t    r_len  = '0;

  iwd_downsizer UUT (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic mismatch_error(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
    $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
    $display("TESTS FAILED");
    $fatal(1, "Wrong value on %s", name);
  endtask

  task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("TESTS FAILED");
    $fatal(1, "%s", what);
  endtask

  // Repeats the last ID half of the time so lanes fill up
  function automatic slv_id_t pick_id(input slv_id_t last_id);
    if ($urandom_range(1) == 0) begin
      return last_id;
    end
    return slv_id_t'($urandom_range(63));
  endfunction

  a_reset_idle : assert property (@(posedge clk_i) reset_i |=> !mst_ar_valid_o)
    else mismatch_error("mst_ar_valid_o", 0, 1);

  a_r_idle : assert property (@(posedge clk_i) !mst_r_valid_i |-> !slv_r_valid_o)
    else mismatch_error("slv_r_valid_o", 0, 1);

  a_ar_latency : assert property (@(posedge clk_i) disable iff (reset_i)
    slv_ar_valid_i && slv_ar_ready_o |=> mst_ar_valid_o)
    else mismatch_error("mst_ar_valid_o", 1, 0);

  // A held master AR fills the issue stage
  a_hold_blocks : assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_valid_o && !mst_ar_ready_i |-> !slv_ar_ready_o)
    else mismatch_error("slv_ar_ready_o", 0, 1);

  always @(negedge clk_i) begin
    if (!reset_i) begin
      slv_ar_hs = slv_ar_valid_i && slv_ar_ready_o;
      mst_ar_hs = mst_ar_valid_o && mst_ar_ready_i;
      r_hs      = slv_r_valid_o && slv_r_ready_i;
      ar_lane   = lane_t'(slv_ar_id_i % `IWD_NUM_IDS);
      // Lane takes a new ID only when drained, the same ID up to the depth
      if (slv_ar_valid_i) begin
        exp_ready = (exp_id_q[ar_lane].size() == 0 ||
                     (exp_id_q[ar_lane][0] == slv_ar_id_i &&
                      exp_id_q[ar_lane].size() < `IWD_MAX_TRANS)) &&
                    (!mst_ar_valid_o || mst_ar_ready_i);
        assert (slv_ar_ready_o == exp_ready)
          else mismatch_error("slv_ar_ready_o", 32'(exp_ready), 32'(slv_ar_ready_o));
      end
      if (held_ar) begin
        assert (mst_ar_valid_o) else mismatch_error("mst_ar_valid_o", 1, 0);
        assert (mst_ar_id_o == held_id)
          else mismatch_error("mst_ar_id_o", 32'(held_id), 32'(mst_ar_id_o));
        assert (mst_ar_addr_o == held_addr)
          else mismatch_error("mst_ar_addr_o", held_addr, mst_ar_addr_o);
        assert (mst_ar_len_o == held_len)
          else mismatch_error("mst_ar_len_o", 32'(held_len), 32'(mst_ar_len_o));
      end
      if (slv_r_valid_o) begin
        assert (slv_r_data_o == mst_r_data_i)
          else mismatch_error("slv_r_data_o", mst_r_data_i, slv_r_data_o);
        assert (slv_r_last_o == mst_r_last_i)
          else mismatch_error("slv_r_last_o", 32'(mst_r_last_i), 32'(slv_r_last_o));
      end
      assert (mst_r_ready_o == slv_r_ready_i)
        else mismatch_error("mst_r_ready_o", 32'(slv_r_ready_i), 32'(mst_r_ready_o));
      if (r_hs) begin
        if (exp_id_q[mst_r_id_i].size() == 0) begin
          abort_run("R beat returned on a lane with no read outstanding");
        end else begin
          head_id = exp_id_q[mst_r_id_i][0];
          assert (slv_r_id_o == head_id)
            else mismatch_error("slv_r_id_o", 32'(head_id), 32'(slv_r_id_o));
          if (mst_r_last_i) begin
            void'(exp_id_q[mst_r_id_i].pop_front());
            reads_done++;
          end
        end
      end
      if (mst_ar_hs) begin
        if (exp_ar_addr_q.size() == 0) begin
          abort_run("Master AR issued with no slave AR pending");
        end else begin
          assert (mst_ar_id_o == exp_ar_id_q[0])
            else mismatch_error("mst_ar_id_o", 32'(exp_ar_id_q[0]), 32'(mst_ar_id_o));
          assert (mst_ar_addr_o == exp_ar_addr_q[0])
            else mismatch_error("mst_ar_addr_o", exp_ar_addr_q[0], mst_ar_addr_o);
          assert (mst_ar_len_o == exp_ar_len_q[0])
            else mismatch_error("mst_ar_len_o", 32'(exp_ar_len_q[0]), 32'(mst_ar_len_o));
          void'(exp_ar_id_q.pop_front());
          void'(exp_ar_addr_q.pop_front());
          void'(exp_ar_len_q.pop_front());
          mem_addr_q[mst_ar_id_o].push_back(mst_ar_addr_o);
          mem_len_q[mst_ar_id_o].push_back(mst_ar_len_o);
        end
      end
      if (slv_ar_hs) begin
        exp_id_q[ar_lane].push_back(slv_ar_id_i);
        exp_ar_id_q.push_back(mst_id_t'(ar_lane));
        exp_ar_addr_q.push_back(slv_ar_addr_i);
        exp_ar_len_q.push_back(slv_ar_len_i);
      end
      held_ar   = mst_ar_valid_o && !mst_ar_ready_i;
      held_id   = mst_ar_id_o;
      held_addr = mst_ar_addr_o;
      held_len  = mst_ar_len_o;
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (slv_ar_hs || !slv_ar_valid_i) begin
        if (reads_sent < NUM_READS && $urandom_range(3) != 0) begin
          slv_ar_valid_i <= 1'b1;
          slv_ar_id_i    <= pick_id(slv_ar_id_i);
          slv_ar_addr_i  <= addr_t'($urandom);
          slv_ar_len_i   <= len_t'($urandom_range(3));
          reads_sent++;
        end else begin
          slv_ar_valid_i <= 1'b0;
        end
      end
      mst_ar_ready_i <= ($urandom_range(3) != 0);
      slv_r_ready_i  <= ($urandom_range(3) != 0);
      // Memory model serves one burst at a time and picks the oldest read of a random ID
      if (r_hs) begin
        if (beat == int'(r_len)) begin
          busy = 1'b0;
        end else begin
          beat = beat + 1;
        end
      end
      if (!busy) begin
        start = $urandom_range(`IWD_NUM_IDS - 1);
        for (int k = 0; k < `IWD_NUM_IDS; k++) begin
          cand = (start + k) % `IWD_NUM_IDS;
          if (!busy && mem_addr_q[cand].size() != 0) begin
            busy   = 1'b1;
            beat   = 0;
            r_id   = mst_id_t'(cand);
            r_addr = mem_addr_q[cand].pop_front();
            r_len  = mem_len_q[cand].pop_front();
          end
        end
      end
      mst_r_valid_i <= busy;
      mst_r_id_i    <= r_id;
      mst_r_data_i  <= r_addr + data_t'(beat);
      mst_r_last_i  <= busy && (beat == int'(r_len));
    end
  end

  initial begin
    void'($urandom(99));
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    wait (reads_done == NUM_READS);
    @(negedge clk_i);
    // Issue stage empty and the lane of the last slave ID drained
    if (!mst_ar_valid_o && slv_ar_ready_o) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run("DUT not idle after the last burst completed");
    end
  end

  // Watchdog allows 20 cycles per read
  initial begin
    #(NUM_READS * 20 * CLK_PERIOD);
    abort_run("Timeout before all reads completed");
  end

endmodule

// File: build.f
+incdir+.
iwd_pkg.sv
iwd_router.sv
iwd_id_lane.sv
iwd_ar_issue.sv
iwd_downsizer.sv
tb_iwd_downsizer.sv

// File: run.sh
#!/bin/sh
# Compiles the read ID downsizer testbench with Verilator and runs it.
# Exits 0 when the simulation output holds the pass message, 1 otherwise.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
  --top-module tb_iwd_downsizer -o tb_iwd_downsizer
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_iwd_downsizer)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
